/* build.f */
hw/ni_pkg.sv
hw/ni_resp_if.sv
hw/axi_request_packer.sv
hw/noc_fifo.sv
hw/noc_response_unpacker.sv
hw/read_reorder_buffer.sv
hw/write_resp_reorder_buffer.sv
hw/ni_master_top.sv
tb/tb_ni_master.sv

/* hw/axi_request_packer.sv */
// Only one of AW, W and AR may be accepted per cycle; there is no arbitration
// W must follow its AW, since it reuses the last write tag and slave ID
`timescale 1ns/1ps

module axi_request_packer import ni_pkg::*; #(
	parameter logic [ID_W-1:0] MASTER_ID = '0
) (
	input  logic              ACLK,
	input  logic              ARESETn,
	input  logic [ID_W-1:0]   AWID,
	input  logic [ADDR_W-1:0] AWADDR,
	input  logic              AWVALID,
	output logic              AWREADY,
	input  logic [ID_W-1:0]   WID,
	input  logic [DATA_W-1:0] WDATA,
	input  logic              WVALID,
	output logic              WREADY,
	input  logic [ID_W-1:0]   ARID,
	input  logic [ADDR_W-1:0] ARADDR,
	input  logic              ARVALID,
	output logic              ARREADY,
	input  logic              fifo_full,      // Outbound FIFO full
	input  logic              fifo_one_left,  // Outbound FIFO has one slot left
	input  logic              wr_full,        // Write reorder buffer full
	input  logic              rd_full,        // Read reorder buffer full
	output logic              pkt_put,        // Packet register holds a new packet
	output noc_pkt_t          pkt,
	output logic              wr_alloc,
	output logic [CTR_W-1:0]  wr_tag,
	output logic [ID_W-1:0]   wr_slave,
	output logic              rd_alloc,
	output logic [ID_W-1:0]   rd_id,
	output logic [CTR_W-1:0]  rd_tag
);

	logic [CTR_W-1:0] wr_ctr [4];            // Per-slave write counters
	logic [CTR_W-1:0] rd_ctr;                // Single read counter
	logic [CTR_W-1:0] last_tag;              // Tag of the last write address
	logic [ID_W-1:0]  last_slave;            // Slave of the last write address
	logic             room;
	logic             aw_fire, w_fire, ar_fire;
	noc_pkt_t         nxt_pkt;

	// ------------------------------------------------------------
	// Ready rules
	// ------------------------------------------------------------
	// Pending packet still needs its own slot next cycle
	assign room    = pkt_put ? (!fifo_full && !fifo_one_left) : !fifo_full;
	assign AWREADY = !wr_full && room;
	assign WREADY  = !wr_full && room;
	assign ARREADY = !rd_full && room;

	assign aw_fire = AWVALID && AWREADY;
	assign w_fire  = WVALID && WREADY;
	assign ar_fire = ARVALID && ARREADY;

	// Reorder buffer allocation in the accepting cycle
	assign wr_alloc = aw_fire;
	assign wr_tag   = wr_ctr[AWADDR[5:4]];
	assign wr_slave = {SLAVE_BASE_ID, AWADDR[5:4]};
	assign rd_alloc = ar_fire;
	assign rd_id    = ARID;
	assign rd_tag   = rd_ctr;

	// ------------------------------------------------------------
	// Packet build, AR over W over AW
	// ------------------------------------------------------------
	always_comb
	begin
		nxt_pkt            = '0;
		nxt_pkt.hdr.master = MASTER_ID;
		nxt_pkt.hdr.valid  = 1'b1;
		if (ar_fire)
		begin
			nxt_pkt.payload.addr_word.addr = ARADDR;
			nxt_pkt.hdr.id    = ARID;
			nxt_pkt.hdr.tag   = rd_ctr;
			nxt_pkt.hdr.slave = {SLAVE_BASE_ID, ARADDR[5:4]};
			nxt_pkt.hdr.ptype = PKT_RD_ADDR;
		end
		else if (w_fire)
		begin
			nxt_pkt.payload.data = WDATA;
			nxt_pkt.hdr.id    = WID;
			nxt_pkt.hdr.tag   = last_tag;          // Same tag as its AW
			nxt_pkt.hdr.slave = last_slave;
			nxt_pkt.hdr.ptype = PKT_WR_DATA;
		end
		else
		begin
			nxt_pkt.payload.addr_word.addr = AWADDR;
			nxt_pkt.hdr.id    = AWID;
			nxt_pkt.hdr.tag   = wr_tag;
			nxt_pkt.hdr.slave = wr_slave;
			nxt_pkt.hdr.ptype = PKT_WR_ADDR;
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (aw_fire || w_fire || ar_fire)
			pkt <= nxt_pkt;
	end

	// Counters and put strobe
	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			pkt_put    <= 1'b0;
			rd_ctr     <= '0;
			last_tag   <= '0;
			last_slave <= {SLAVE_BASE_ID, 2'b00};
			for (int i = 0; i < 4; i++)
				wr_ctr[i] <= '0;
		end
		else
		begin
			pkt_put <= aw_fire || w_fire || ar_fire;  // Strobe one cycle after accept
			if (aw_fire)
			begin
				wr_ctr[AWADDR[5:4]] <= wr_tag + 1'b1;
				last_tag            <= wr_tag;
				last_slave          <= wr_slave;
			end
			if (ar_fire)
				rd_ctr <= rd_ctr + 1'b1;
		end
	end

endmodule

/* hw/ni_master_top.sv */
// Master-side network interface; one AXI channel accepted per cycle
// Responses return to the master in issue order whatever the router order
`timescale 1ns/1ps

module ni_master_top import ni_pkg::*; #(
	parameter logic [ID_W-1:0] MASTER_ID  = '0,
	parameter int              FIFO_DEPTH = 8,
	parameter int              ROB_DEPTH  = 8
) (
	input  logic              ACLK,
	input  logic              ARESETn,
	input  logic [ID_W-1:0]   AWID,
	input  logic [ADDR_W-1:0] AWADDR,
	input  logic              AWVALID,
	output logic              AWREADY,
	input  logic [ID_W-1:0]   WID,
	input  logic [DATA_W-1:0] WDATA,
	input  logic              WVALID,
	output logic              WREADY,
	output logic [ID_W-1:0]   BID,
	output logic [1:0]        BRESP,
	output logic              BVALID,
	input  logic              BREADY,
	input  logic [ID_W-1:0]   ARID,
	input  logic [ADDR_W-1:0] ARADDR,
	input  logic              ARVALID,
	output logic              ARREADY,
	output logic [ID_W-1:0]   RID,
	output logic [DATA_W-1:0] RDATA,
	output logic              RVALID,
	input  logic              RREADY,
	output logic [PKT_W-1:0]  M2R_data_out,   // Outbound FIFO head
	output logic              IF_valid,
	input  logic              router_ready,
	input  logic [PKT_W-1:0]  R2M_data_input,
	input  logic              router_valid,
	output logic              IF_ready
);

	noc_pkt_t         pkt, r2m_head;
	logic             pkt_put;
	logic             m2r_empty, m2r_full, m2r_one_left;
	logic             r2m_empty, r2m_full, r2m_get;
	logic             wr_alloc, rd_alloc, wr_full, rd_full;
	logic [CTR_W-1:0] wr_tag, rd_tag;
	logic [ID_W-1:0]  wr_slave, rd_id;

	ni_resp_if resp_if ();

	// Router handshake levels
	assign IF_valid = !m2r_empty;
	assign IF_ready = !r2m_full;

	axi_request_packer #(.MASTER_ID(MASTER_ID)) u_packer (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.AWID(AWID), .AWADDR(AWADDR), .AWVALID(AWVALID), .AWREADY(AWREADY),
		.WID(WID), .WDATA(WDATA), .WVALID(WVALID), .WREADY(WREADY),
		.ARID(ARID), .ARADDR(ARADDR), .ARVALID(ARVALID), .ARREADY(ARREADY),
		.fifo_full(m2r_full), .fifo_one_left(m2r_one_left),
		.wr_full(wr_full), .rd_full(rd_full),
		.pkt_put(pkt_put), .pkt(pkt),
		.wr_alloc(wr_alloc), .wr_tag(wr_tag), .wr_slave(wr_slave),
		.rd_alloc(rd_alloc), .rd_id(rd_id), .rd_tag(rd_tag)
	);

	// Master to router
	noc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) m2r_fifo (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.put(pkt_put && !m2r_full), .get(router_ready && !m2r_empty),
		.data_in(pkt), .data_out(M2R_data_out),
		.empty(m2r_empty), .full(m2r_full), .one_left(m2r_one_left)
	);

	// Router to master, space check only
	noc_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) r2m_fifo (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.put(router_valid && !r2m_full), .get(r2m_get),
		.data_in(R2M_data_input), .data_out(r2m_head),
		.empty(r2m_empty), .full(r2m_full), .one_left()
	);

	noc_response_unpacker u_unpacker (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.fifo_empty(r2m_empty), .fifo_head(r2m_head), .fifo_get(r2m_get),
		.resp(resp_if.src)
	);

	read_reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_rd_rob (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.alloc(rd_alloc), .alloc_id(rd_id), .alloc_tag(rd_tag),
		.resp(resp_if.rd_sink),
		.RID(RID), .RDATA(RDATA), .RVALID(RVALID), .RREADY(RREADY),
		.full(rd_full)
	);

	write_resp_reorder_buffer #(.ROB_DEPTH(ROB_DEPTH)) u_wr_rob (
		.ACLK(ACLK), .ARESETn(ARESETn),
		.alloc(wr_alloc), .alloc_tag(wr_tag), .alloc_slave(wr_slave),
		.resp(resp_if.wr_sink),
		.BID(BID), .BRESP(BRESP), .BVALID(BVALID), .BREADY(BREADY),
		.full(wr_full)
	);

endmodule

/* hw/ni_pkg.sv */
// Shared widths and packet layout of the master-side network interface
// Header sits in the low 32 bits and the payload in bits 159:32 of every packet
package ni_pkg;

	localparam int ADDR_W = 32;              // Master address width
	localparam int DATA_W = 128;             // Master data width
	localparam int ID_W   = 3;               // Transaction, master and slave ID width
	localparam int CTR_W  = 3;               // Tag counter width, 8 tags in flight
	localparam int PKT_W  = 160;             // Full packet width

	// Slave ID is this bit followed by address bits 5:4
	localparam logic SLAVE_BASE_ID = 1'b1;

	// Packet type codes as seen by the router and the slaves
	typedef enum logic [2:0] {
		PKT_WR_ADDR = 3'd0,
		PKT_WR_DATA = 3'd1,
		PKT_RD_ADDR = 3'd2,
		PKT_WR_RESP = 3'd3,
		PKT_RD_DATA = 3'd4
	} pkt_type_t;

	// Payload word, either full data or an address in the low bits
	typedef union packed {
		logic [DATA_W-1:0] data;                 // W and read data packets
		struct packed {
			logic [DATA_W-ADDR_W-1:0] pad;         // Zero fill
			logic [ADDR_W-1:0]        addr;        // AW and AR packets
		} addr_word;
	} pkt_payload_u;

	// Packet header, 32 bits
	typedef struct packed {
		logic [ID_W-1:0]  id;                    // Transaction ID
		logic [CTR_W-1:0] tag;                   // Counter tag
		logic [ID_W-1:0]  master;                // Master ID
		logic [ID_W-1:0]  slave;                 // Slave ID
		pkt_type_t        ptype;                 // Packet type
		logic             valid;                 // Always set by the packer
		logic [15:0]      low;                   // Write response: [4:3] BRESP, [2:0] BID
	} pkt_hdr_t;

	// Whole packet
	typedef struct packed {
		pkt_payload_u payload;
		pkt_hdr_t     hdr;
	} noc_pkt_t;

endpackage

/* hw/ni_resp_if.sv */
// Unpacked responses from the router side, one-cycle pulses without back-pressure
`timescale 1ns/1ps

interface ni_resp_if import ni_pkg::*; ();

	logic              rd_valid;             // Read data pulse
	logic              wr_valid;             // Write response pulse
	logic [CTR_W-1:0]  tag;                  // Counter tag from the header
	logic [ID_W-1:0]   slave_id;             // Responding slave
	logic [DATA_W-1:0] data;                 // Read data
	logic [ID_W-1:0]   bid;                  // Write response ID
	logic [1:0]        bresp;                // Write response code

	// Unpacker side
	modport src (output rd_valid, wr_valid, tag, slave_id, data, bid, bresp);

	// Read reorder buffer only needs the tag and the data
	modport rd_sink (input rd_valid, tag, data);

	// Write reorder buffer matches on tag and slave
	modport wr_sink (input wr_valid, tag, slave_id, bid, bresp);

endinterface

/* hw/noc_fifo.sv */
// FIFO_DEPTH must be a power of two, at least 2
// Caller must not put when full nor get when empty; head shows without read latency
`timescale 1ns/1ps

module noc_fifo import ni_pkg::*; #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic     ACLK,
	input  logic     ARESETn,
	input  logic     put,
	input  logic     get,
	input  noc_pkt_t data_in,
	output noc_pkt_t data_out,
	output logic     empty,
	output logic     full,
	output logic     one_left                // Exactly one free slot
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] CAP      = (AW+1)'(FIFO_DEPTH);
	localparam logic [AW:0] CAP_LESS = (AW+1)'(FIFO_DEPTH - 1);

	noc_pkt_t    mem [FIFO_DEPTH];
	logic [AW:0] wr_ptr, rd_ptr;             // Extra MSB is the wrap bit
	logic [AW:0] fill_cnt;

	// ------------------------------------------------------------
	// Flags
	// ------------------------------------------------------------
	assign fill_cnt = wr_ptr - rd_ptr;
	assign empty    = (wr_ptr == rd_ptr);
	assign full     = (fill_cnt == CAP);
	assign one_left = (fill_cnt == CAP_LESS);
	assign data_out = mem[rd_ptr[AW-1:0]];  // Head, no read latency

	// Storage
	always_ff @(posedge ACLK)
	begin
		if (put)
			mem[wr_ptr[AW-1:0]] <= data_in;
	end

	// Pointers
	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (put)
				wr_ptr <= wr_ptr + 1'b1;
			if (get)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

/* hw/noc_response_unpacker.sv */
// Pops every inbound packet; unknown types are discarded
`timescale 1ns/1ps

module noc_response_unpacker import ni_pkg::*; (
	input  logic     ACLK,
	input  logic     ARESETn,
	input  logic     fifo_empty,
	input  noc_pkt_t fifo_head,
	output logic     fifo_get,
	ni_resp_if.src   resp
);

	assign fifo_get = !fifo_empty;           // Always drain

	// Response pulses, one cycle after the pop
	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			resp.rd_valid <= 1'b0;
			resp.wr_valid <= 1'b0;
		end
		else
		begin
			resp.rd_valid <= fifo_get && (fifo_head.hdr.ptype == PKT_RD_DATA);
			resp.wr_valid <= fifo_get && (fifo_head.hdr.ptype == PKT_WR_RESP);
		end
	end

	// ------------------------------------------------------------
	// Payload fields, taken on every pop
	// ------------------------------------------------------------
	always_ff @(posedge ACLK)
	begin
		if (fifo_get)
		begin
			resp.tag      <= fifo_head.hdr.tag;
			resp.slave_id <= fifo_head.hdr.slave;
			resp.data     <= fifo_head.payload.data;    // Data view of the payload
			resp.bid      <= fifo_head.hdr.low[2:0];    // BID in the low bits
			resp.bresp    <= fifo_head.hdr.low[4:3];
		end
	end

endmodule

/* hw/read_reorder_buffer.sv */
// ROB_DEPTH is a power of two from 2 to 8, within the 8-tag space
// Returned data for a tag that is not outstanding is dropped
`timescale 1ns/1ps

module read_reorder_buffer import ni_pkg::*; #(
	parameter int ROB_DEPTH = 8
) (
	input  logic              ACLK,
	input  logic              ARESETn,
	input  logic              alloc,          // Read address accepted
	input  logic [ID_W-1:0]   alloc_id,
	input  logic [CTR_W-1:0]  alloc_tag,
	ni_resp_if.rd_sink        resp,
	output logic [ID_W-1:0]   RID,
	output logic [DATA_W-1:0] RDATA,
	output logic              RVALID,
	input  logic              RREADY,
	output logic              full
);

	localparam int PW = $clog2(ROB_DEPTH);
	localparam logic [PW:0] CAP = (PW+1)'(ROB_DEPTH);

	logic [ROB_DEPTH-1:0] used;              // Entry allocated
	logic [ROB_DEPTH-1:0] filled;            // Data returned
	logic [ID_W-1:0]      id_q   [ROB_DEPTH];
	logic [CTR_W-1:0]     tag_q  [ROB_DEPTH];
	logic [DATA_W-1:0]    data_q [ROB_DEPTH];
	logic [PW:0]          wr_ptr, rd_ptr;
	logic [PW-1:0]        head, hit_idx;
	logic                 hit;

	assign head   = rd_ptr[PW-1:0];
	assign full   = ((wr_ptr - rd_ptr) == CAP);
	assign RVALID = used[head] && filled[head];  // Head in issue order
	assign RID    = id_q[head];
	assign RDATA  = data_q[head];

	// Lowest outstanding entry with a matching tag
	always_comb
	begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = ROB_DEPTH - 1; i >= 0; i--)
		begin
			if (used[i] && !filled[i] && (tag_q[i] == resp.tag))
			begin
				hit     = 1'b1;
				hit_idx = PW'(i);
			end
		end
	end

	// ------------------------------------------------------------
	// Entry payload
	// ------------------------------------------------------------
	always_ff @(posedge ACLK)
	begin
		if (alloc)
		begin
			id_q[wr_ptr[PW-1:0]]  <= alloc_id;
			tag_q[wr_ptr[PW-1:0]] <= alloc_tag;
		end
		if (resp.rd_valid && hit)
			data_q[hit_idx] <= resp.data;
	end

	// Control state
	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			used   <= '0;
			filled <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (alloc)
			begin
				used[wr_ptr[PW-1:0]] <= 1'b1;
				wr_ptr               <= wr_ptr + 1'b1;
			end
			if (resp.rd_valid && hit)
				filled[hit_idx] <= 1'b1;
			if (RVALID && RREADY)                  // Retire head
			begin
				used[head]   <= 1'b0;
				filled[head] <= 1'b0;
				rd_ptr       <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* hw/write_resp_reorder_buffer.sv */
// ROB_DEPTH is a power of two from 2 to 8; tag plus slave ID must be unique in flight
// A response for an unknown tag and slave pair is dropped
`timescale 1ns/1ps

module write_resp_reorder_buffer import ni_pkg::*; #(
	parameter int ROB_DEPTH = 8
) (
	input  logic             ACLK,
	input  logic             ARESETn,
	input  logic             alloc,           // Write address accepted
	input  logic [CTR_W-1:0] alloc_tag,
	input  logic [ID_W-1:0]  alloc_slave,
	ni_resp_if.wr_sink       resp,
	output logic [ID_W-1:0]  BID,
	output logic [1:0]       BRESP,
	output logic             BVALID,
	input  logic             BREADY,
	output logic             full
);

	localparam int PW = $clog2(ROB_DEPTH);
	localparam logic [PW:0] CAP = (PW+1)'(ROB_DEPTH);

	logic [ROB_DEPTH-1:0] used;
	logic [ROB_DEPTH-1:0] filled;
	logic [CTR_W-1:0]     tag_q   [ROB_DEPTH];
	logic [ID_W-1:0]      slave_q [ROB_DEPTH];
	logic [ID_W-1:0]      bid_q   [ROB_DEPTH];
	logic [1:0]           bresp_q [ROB_DEPTH];
	logic [PW:0]          wr_ptr, rd_ptr;
	logic [PW-1:0]        head, hit_idx;
	logic                 hit;

	assign head   = rd_ptr[PW-1:0];
	assign full   = ((wr_ptr - rd_ptr) == CAP);
	assign BVALID = used[head] && filled[head];
	assign BID    = bid_q[head];
	assign BRESP  = bresp_q[head];

	// Counters are per slave, so tag alone is not enough
	always_comb
	begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = ROB_DEPTH - 1; i >= 0; i--)
		begin
			if (used[i] && !filled[i] && (tag_q[i] == resp.tag) &&
				(slave_q[i] == resp.slave_id))
			begin
				hit     = 1'b1;
				hit_idx = PW'(i);
			end
		end
	end

	// ------------------------------------------------------------
	// Entry payload
	// ------------------------------------------------------------
	always_ff @(posedge ACLK)
	begin
		if (alloc)
		begin
			tag_q[wr_ptr[PW-1:0]]   <= alloc_tag;
			slave_q[wr_ptr[PW-1:0]] <= alloc_slave;
		end
		if (resp.wr_valid && hit)
		begin
			bid_q[hit_idx]   <= resp.bid;
			bresp_q[hit_idx] <= resp.bresp;
		end
	end

	always_ff @(posedge ACLK)
	begin
		if (!ARESETn)
		begin
			used   <= '0;
			filled <= '0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (alloc)
			begin
				used[wr_ptr[PW-1:0]] <= 1'b1;
				wr_ptr               <= wr_ptr + 1'b1;
			end
			if (resp.wr_valid && hit)
				filled[hit_idx] <= 1'b1;
			if (BVALID && BREADY)                  // Head leaves on handshake
			begin
				used[head]   <= 1'b0;
				filled[head] <= 1'b0;
				rd_ptr       <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module tb_ni_master \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_ni_master > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || { echo "Run ended without a result"; exit 1; }
exit 0

/* tb/tb_ni_master.sv */
// Testbench plays the AXI master and the router around ni_master_top
// Each phase issues its rows, checks the packets, then answers in rank order
// Only one master channel is driven per cycle, as the DUT requires
`timescale 1ns/1ps

module tb_ni_master import ni_pkg::*; ();

	localparam logic [ID_W-1:0] MASTER = 3'd2;
	localparam int N_ROWS     = 12;
	localparam int TIMEOUT_NS = N_ROWS * 200 * 4;   // 200 cycles of 4 ns per row

	// One master request; rank is the position in the router's answer order
	typedef struct packed {
		logic              is_rd;
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [3:0]        rank;
		logic [1:0]        phase;
	} row_t;

	// Address bits 5:4 pick the slave; slave 5 gets three writes over the run
	localparam row_t STIM [N_ROWS] = '{
		'{1'b0, 3'd1, 32'h1000_0010, 128'ha0a0_0001_1111_2222_3333_4444_5555_6666, 4'd3, 2'd0},
		'{1'b0, 3'd2, 32'h1000_0020, 128'hb1b1_0002_0123_4567_89ab_cdef_0f0f_f0f0, 4'd1, 2'd0},
		'{1'b0, 3'd3, 32'h1000_0014, 128'hc2c2_0003_fedc_ba98_7654_3210_aaaa_5555, 4'd0, 2'd0},
		'{1'b0, 3'd4, 32'h2000_0030, 128'hd3d3_0004_1357_9bdf_0246_8ace_ffff_0000, 4'd2, 2'd0},
		'{1'b1, 3'd5, 32'h3000_0000, 128'he4e4_0005_0000_1111_2222_3333_4444_5555, 4'd2, 2'd1},
		'{1'b1, 3'd6, 32'h3000_0110, 128'hf5f5_0006_9999_8888_7777_6666_5555_4444, 4'd0, 2'd1},
		'{1'b1, 3'd7, 32'h3000_0020, 128'h0606_0007_abcd_ef01_2345_6789_1a2b_3c4d, 4'd3, 2'd1},
		'{1'b1, 3'd0, 32'h3000_0030, 128'h1717_0008_5a5a_a5a5_3c3c_c3c3_0ff0_f00f, 4'd1, 2'd1},
		'{1'b0, 3'd6, 32'h1000_0018, 128'h2828_0009_1234_5678_9abc_def0_1234_5678, 4'd1, 2'd2},
		'{1'b1, 3'd5, 32'h4000_0024, 128'h3939_000a_cafe_f00d_beef_babe_0000_0001, 4'd3, 2'd2},
		'{1'b0, 3'd7, 32'h5000_0008, 128'h4a4a_000b_0101_0202_0303_0404_0505_0606, 4'd0, 2'd2},
		'{1'b1, 3'd0, 32'h4000_003c, 128'h5b5b_000c_7777_0000_7777_0000_7777_0000, 4'd2, 2'd2}
	};

	logic              ACLK, ARESETn;
	logic [ID_W-1:0]   AWID, WID, ARID, BID, RID;
	logic [ADDR_W-1:0] AWADDR, ARADDR;
	logic [DATA_W-1:0] WDATA, RDATA;
	logic              AWVALID, AWREADY, WVALID, WREADY, ARVALID, ARREADY;
	logic [1:0]        BRESP;
	logic              BVALID, BREADY, RVALID, RREADY;
	logic [PKT_W-1:0]  M2R_data_out, R2M_data_input;
	logic              IF_valid, router_ready, router_valid, IF_ready;

	noc_pkt_t          exp_pkts [$];         // Expected outbound packets of the phase
	noc_pkt_t          cap_pkts [$];         // Packets seen by the router model
	logic [ID_W-1:0]   exp_bid [$], exp_rid [$];
	logic [1:0]        exp_bresp [$];
	logic [DATA_W-1:0] exp_rdata [$];
	int                row_pkt [N_ROWS];     // First packet index of each row
	logic [CTR_W-1:0]  wr_cnt [4];           // Model of the per-slave write tags
	logic [CTR_W-1:0]  rd_cnt;
	int                n_wr, n_rd;

	ni_master_top #(.MASTER_ID(MASTER), .FIFO_DEPTH(8), .ROB_DEPTH(8)) uut (.*);

	initial ACLK = 1'b0;
	always #2 ACLK = ~ACLK;                  // 4 ns period

	// ------------------------------------------------------------
	// Compare and stop at the first mismatch
	// ------------------------------------------------------------
	task automatic check_eq(input logic [PKT_W-1:0] got, input logic [PKT_W-1:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("Fail at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			$display("Verification failed");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	// Build the expected packets and responses of one phase
	task automatic plan_phase(input int p);
		row_t     r;
		noc_pkt_t e;
		exp_pkts.delete();
		cap_pkts.delete();
		exp_bid.delete();
		exp_bresp.delete();
		exp_rid.delete();
		exp_rdata.delete();
		n_wr = 0;
		n_rd = 0;
		for (int i = 0; i < N_ROWS; i++)
		begin
			r = STIM[i];
			if (int'(r.phase) == p)
			begin
				e            = '0;
				e.hdr.master = MASTER;
				e.hdr.valid  = 1'b1;
				e.hdr.id     = r.id;
				e.hdr.slave  = {1'b1, r.addr[5:4]};  // Fixed leading one
				row_pkt[i]   = exp_pkts.size();
				if (r.is_rd)
				begin
					e.hdr.tag   = rd_cnt;
					rd_cnt      = rd_cnt + 3'd1;
					e.hdr.ptype = PKT_RD_ADDR;
					e.payload.addr_word.addr = r.addr;
					exp_pkts.push_back(e);
					exp_rid.push_back(r.id);
					exp_rdata.push_back(r.data);
					n_rd++;
				end
				else
				begin
					e.hdr.tag   = wr_cnt[r.addr[5:4]];
					wr_cnt[r.addr[5:4]] = wr_cnt[r.addr[5:4]] + 3'd1;
					e.hdr.ptype = PKT_WR_ADDR;
					e.payload.addr_word.addr = r.addr;
					exp_pkts.push_back(e);
					e.payload.data = r.data;         // W packet keeps the AW tag and slave
					e.hdr.ptype    = PKT_WR_DATA;
					exp_pkts.push_back(e);
					exp_bid.push_back(r.id);
					exp_bresp.push_back(r.rank[1:0]);
					n_wr++;
				end
			end
		end
	endtask

	// ------------------------------------------------------------
	// Master side
	// ------------------------------------------------------------
	task automatic send_request(input row_t r);
		bit done;
		@(posedge ACLK);
		#0.5;
		if (r.is_rd)
		begin
			ARID    = r.id;
			ARADDR  = r.addr;
			ARVALID = 1'b1;
			done    = 1'b0;
			while (!done)
			begin
				#1 done = ARREADY;                 // Stable until the next edge
				@(posedge ACLK);
				#0.5;
			end
			ARVALID = 1'b0;
		end
		else
		begin
			AWID    = r.id;
			AWADDR  = r.addr;
			AWVALID = 1'b1;
			done    = 1'b0;
			while (!done)
			begin
				#1 done = AWREADY;
				@(posedge ACLK);
				#0.5;
			end
			AWVALID = 1'b0;
			WID     = r.id;                      // Data right behind its address
			WDATA   = r.data;
			WVALID  = 1'b1;
			done    = 1'b0;
			while (!done)
			begin
				#1 done = WREADY;
				@(posedge ACLK);
				#0.5;
			end
			WVALID = 1'b0;
		end
	endtask

	task automatic drive_rows(input int p);
		for (int i = 0; i < N_ROWS; i++)
			if (int'(STIM[i].phase) == p)
				send_request(STIM[i]);
	endtask

	// ------------------------------------------------------------
	// Router side
	// ------------------------------------------------------------
	task automatic capture_packets(input int p, input bit stall);
		int       got;
		int       hold;
		noc_pkt_t pk;
		got  = 0;
		hold = 0;
		while (got < exp_pkts.size())
		begin
			@(posedge ACLK);
			#0.5;
			if (hold > 0)
			begin
				router_ready = 1'b0;               // Inside a stall
				hold--;
			end
			else if (stall && ($urandom % 3 == 0))
			begin
				router_ready = 1'b0;
				hold = $urandom % 5;
			end
			else
				router_ready = 1'b1;
			#1;
			if (IF_valid && router_ready)        // Leaves at the next edge
			begin
				pk = M2R_data_out;
				check_eq(160'(pk), 160'(exp_pkts[got]),
					$sformatf("phase %0d packet %0d", p, got));
				cap_pkts.push_back(pk);
				got++;
			end
		end
		@(posedge ACLK);
		#0.5 router_ready = 1'b0;              // Extra packets would stay visible
	endtask

	// Answer in rank order with tag and slave taken from the captured request
	task automatic send_responses(input int p);
		noc_pkt_t rp;
		row_t     r;
		bit       done;
		for (int k = 0; k < n_wr + n_rd; k++)
			for (int i = 0; i < N_ROWS; i++)
			begin
				r = STIM[i];
				if (int'(r.phase) == p && int'(r.rank) == k)
				begin
					rp            = '0;
					rp.hdr.tag    = cap_pkts[row_pkt[i]].hdr.tag;
					rp.hdr.slave  = cap_pkts[row_pkt[i]].hdr.slave;
					rp.hdr.master = MASTER;
					rp.hdr.id     = r.id;
					rp.hdr.valid  = 1'b1;
					if (r.is_rd)
					begin
						rp.hdr.ptype    = PKT_RD_DATA;
						rp.payload.data = r.data;
					end
					else
					begin
						rp.hdr.ptype    = PKT_WR_RESP;
						rp.hdr.low[2:0] = r.id;            // BID
						rp.hdr.low[4:3] = r.rank[1:0];     // BRESP
					end
					repeat ($urandom % 3) @(posedge ACLK);
					@(posedge ACLK);
					#0.5;
					router_valid   = 1'b1;
					R2M_data_input = rp;
					done           = 1'b0;
					while (!done)
					begin
						#1 done = IF_ready;
						@(posedge ACLK);
						#0.5;
					end
					router_valid = 1'b0;
				end
			end
	endtask

	// B and R collection; readies stay low for the first hold cycles
	task automatic collect_responses(input int hold);
		int              got_w, got_r, cyc;
		bit              seen_b, seen_r;
		logic [ID_W-1:0] held_bid, held_rid;
		logic [1:0]      held_bresp;
		logic [DATA_W-1:0] held_rdata;
		got_w  = 0;
		got_r  = 0;
		cyc    = 0;
		seen_b = 1'b0;
		seen_r = 1'b0;
		while (got_w < n_wr || got_r < n_rd)
		begin
			@(posedge ACLK);
			#0.5;
			BREADY = (cyc >= hold);
			RREADY = (cyc >= hold);
			#1;
			if (BVALID && BREADY)
			begin
				check_eq(160'(got_w < n_wr), 160'(1'b1), "unexpected write response");
				check_eq(160'(BID), 160'(exp_bid[got_w]), $sformatf("BID %0d", got_w));
				check_eq(160'(BRESP), 160'(exp_bresp[got_w]), $sformatf("BRESP %0d", got_w));
				got_w++;
			end
			else if (BVALID && seen_b)           // Held head must not move
			begin
				check_eq(160'(BID), 160'(held_bid), "held BID");
				check_eq(160'(BRESP), 160'(held_bresp), "held BRESP");
			end
			else if (BVALID)
			begin
				seen_b     = 1'b1;
				held_bid   = BID;
				held_bresp = BRESP;
			end
			if (RVALID && RREADY)
			begin
				check_eq(160'(got_r < n_rd), 160'(1'b1), "unexpected read data");
				check_eq(160'(RID), 160'(exp_rid[got_r]), $sformatf("RID %0d", got_r));
				check_eq(160'(RDATA), 160'(exp_rdata[got_r]), $sformatf("RDATA %0d", got_r));
				got_r++;
			end
			else if (RVALID && seen_r)
			begin
				check_eq(160'(RID), 160'(held_rid), "held RID");
				check_eq(160'(RDATA), 160'(held_rdata), "held RDATA");
			end
			else if (RVALID)
			begin
				seen_r     = 1'b1;
				held_rid   = RID;
				held_rdata = RDATA;
			end
			cyc++;
		end
		@(posedge ACLK);
		#0.5;
		BREADY = 1'b0;
		RREADY = 1'b0;
	endtask

	task automatic run_phase(input int p, input bit stall, input int hold);
		plan_phase(p);
		fork
			drive_rows(p);
			capture_packets(p, stall);
		join
		fork
			send_responses(p);
			collect_responses(hold);
		join
		repeat (2) @(posedge ACLK);
		#1.5;
		check_eq(160'(IF_valid), 160'(1'b0), "IF_valid at phase end");   // Nothing duplicated
		check_eq(160'(BVALID), 160'(1'b0), "BVALID at phase end");
		check_eq(160'(RVALID), 160'(1'b0), "RVALID at phase end");
	endtask

	// ------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------
	initial
	begin
		ARESETn        = 1'b0;
		AWID           = '0;
		AWADDR         = '0;
		AWVALID        = 1'b0;
		WID            = '0;
		WDATA          = '0;
		WVALID         = 1'b0;
		ARID           = '0;
		ARADDR         = '0;
		ARVALID        = 1'b0;
		BREADY         = 1'b0;
		RREADY         = 1'b0;
		router_ready   = 1'b0;
		router_valid   = 1'b0;
		R2M_data_input = '0;
		rd_cnt         = '0;
		for (int i = 0; i < 4; i++)
			wr_cnt[i] = '0;
		void'($urandom(32'hcf8b));
		repeat (2) @(posedge ACLK);
		#0.5 ARESETn = 1'b1;
		#1;
		check_eq(160'(AWREADY), 160'(1'b1), "AWREADY after reset");
		check_eq(160'(WREADY), 160'(1'b1), "WREADY after reset");
		check_eq(160'(ARREADY), 160'(1'b1), "ARREADY after reset");
		check_eq(160'(BVALID), 160'(1'b0), "BVALID after reset");
		check_eq(160'(RVALID), 160'(1'b0), "RVALID after reset");
		check_eq(160'(IF_valid), 160'(1'b0), "IF_valid after reset");
		check_eq(160'(IF_ready), 160'(1'b1), "IF_ready after reset");
		run_phase(0, 1'b0, 0);                 // Writes answered out of order
		run_phase(1, 1'b0, 0);                 // Reads answered out of order
		run_phase(2, 1'b1, 24);                // Mixed traffic with router stalls and held heads
		$display("Verification passed");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
		$display("Verification failed");
		$fatal(1, "Watchdog expired");
	end

endmodule
